// File: compile.f
verilog/msp430Pkg.sv
verilog/InstructionDecoder.sv
verilog/ConstantGenerator.sv
verilog/RegisterFile.sv
verilog/OperandFetch.sv
verilog/OperandUnit.sv
tests/OperandUnitProps.sv
tests/OperandUnitTb.sv

// File: tests/OperandUnitTb.sv
// directed testbench for OperandUnit, loads registers over APB and checks fetched operands
module OperandUnitTb;
    import msp430Pkg::*;

    // cycles per test, APB ops and instructions take three cycles each
    localparam int testCycles = 10 + 144 + 57 + 96 + 78 + 24 + 42;
    localparam int timeoutCycles = testCycles + 200;

    logic                    clk;
    logic                    rstN;
    logic [dataWidth-1:0]    iw;
    logic                    iwValid;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [apbAddrWidth-1:0] paddr;
    logic [dataWidth-1:0]    pwdata;
    logic [dataWidth-1:0]    prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    opValid;
    logic [dataWidth-1:0]    srcOperand;
    logic [dataWidth-1:0]    dstOperand;
    logic                    srcIsConst;
    logic                    dstIsConst;

    // model of the register file contents
    logic [dataWidth-1:0] shadow [numRegs];

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;

    OperandUnit i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .iw         (iw),
        .iwValid    (iwValid),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .opValid    (opValid),
        .srcOperand (srcOperand),
        .dstOperand (dstOperand),
        .srcIsConst (srcIsConst),
        .dstIsConst (dstIsConst)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin : watchdog
        wait (cycles >= timeoutCycles);
        $display("timeout: run still going after %0d cycles", timeoutCycles);
        $display("Regression failed");
        $finish;
    end

    // inputs change just after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compareWord(input string name, input logic [dataWidth-1:0] got,
                               input logic [dataWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        tests++;
        if (errors == errBefore) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s FAILED with %0d errors", name, errors - errBefore);
        end
    endtask

    // setup, access, then idle so no access phase repeats
    task automatic apbWrite(input logic [apbAddrWidth-1:0] addr,
                            input logic [dataWidth-1:0] data, input logic expErr);
        nextCycle();
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        nextCycle();
        penable = 1'b1;
        #1;
        compareFlag("pready", pready, 1'b1);
        compareFlag("pslverr", pslverr, expErr);
        nextCycle();
        psel = 1'b0;
        penable = 1'b0;
        // a rejected write must not change anything
        if (!expErr) begin
            shadow[addr[4:1]] = data;
        end
    endtask

    task automatic apbRead(input logic [apbAddrWidth-1:0] addr, input logic expErr);
        nextCycle();
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        nextCycle();
        penable = 1'b1;
        #1;
        compareFlag("pready", pready, 1'b1);
        compareFlag("pslverr", pslverr, expErr);
        if (!expErr) begin
            compareWord("prdata", prdata, shadow[addr[4:1]]);
        end
        nextCycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // constant table for the two-bit mode, result is {hit, value}
    function automatic logic [dataWidth:0] refConst(input logic [3:0] r, input logic [1:0] m);
        case ({r, m})
            {regCg1, 2'd1}: return {1'b1, 16'h0000};
            {regCg1, 2'd2}: return {1'b1, 16'h0004};
            {regCg1, 2'd3}: return {1'b1, 16'h0008};
            {regCg2, 2'd0}: return {1'b1, 16'h0000};
            {regCg2, 2'd1}: return {1'b1, 16'h0001};
            {regCg2, 2'd2}: return {1'b1, 16'h0002};
            {regCg2, 2'd3}: return {1'b1, 16'hffff};
            default: return '0;
        endcase
    endfunction

    task automatic checkOperands(input logic [dataWidth-1:0] word);
        logic [dataWidth:0]   c;
        logic [3:0]           dReg;
        logic [dataWidth-1:0] expSrc;
        logic [dataWidth-1:0] expDst;
        logic                 expSrcC;
        logic                 expDstC;
        dReg = word[3:0];
        if (word[15:14] == 2'b00) begin
            // single operand or jump, operand travels on dst
            c = refConst(dReg, word[5:4]);
            expSrc = '0;
            expSrcC = 1'b0;
            expDstC = c[dataWidth];
            expDst = expDstC ? c[dataWidth-1:0] : shadow[dReg];
        end else begin
            c = refConst(word[11:8], word[5:4]);
            expSrcC = c[dataWidth];
            expSrc = expSrcC ? c[dataWidth-1:0] : shadow[word[11:8]];
            // Ad is one bit, CG2 always generates, CG1 only when indexed
            if (dReg == regCg1 && word[7]) begin
                expDst = 16'h0000;
                expDstC = 1'b1;
            end else if (dReg == regCg2) begin
                expDst = word[7] ? 16'h0001 : 16'h0000;
                expDstC = 1'b1;
            end else begin
                expDst = shadow[dReg];
                expDstC = 1'b0;
            end
        end
        compareWord("srcOperand", srcOperand, expSrc);
        compareWord("dstOperand", dstOperand, expDst);
        compareFlag("srcIsConst", srcIsConst, expSrcC);
        compareFlag("dstIsConst", dstIsConst, expDstC);
    endtask

    // one instruction alone in the pipe, result two edges after capture
    task automatic issueInstr(input logic [dataWidth-1:0] word);
        nextCycle();
        iw = word;
        iwValid = 1'b1;
        nextCycle();
        iwValid = 1'b0;
        nextCycle();
        compareFlag("opValid", opValid, 1'b1);
        checkOperands(word);
    endtask

    task automatic loadReadback();
        int          e0;
        logic [31:0] rnd;
        e0 = errors;
        // everything reads zero out of reset
        for (int r = 0; r < numRegs; r++) begin
            apbRead(8'(2 * r), 1'b0);
        end
        for (int r = 0; r < numRegs; r++) begin
            rnd = $urandom;
            apbWrite(8'(2 * r), rnd[15:0], 1'b0);
        end
        for (int r = 0; r < numRegs; r++) begin
            apbRead(8'(2 * r), 1'b0);
        end
        reportTest("loadReadback", e0);
    endtask

    task automatic errorResponse();
        int e0;
        e0 = errors;
        apbWrite(8'h07, 16'hdead, 1'b1);
        apbWrite(8'h22, 16'hbeef, 1'b1);
        apbRead(8'h40, 1'b1);
        for (int r = 0; r < numRegs; r++) begin
            apbRead(8'(2 * r), 1'b0);
        end
        reportTest("errorResponse", e0);
    endtask

    task automatic doubleConstants();
        int         e0;
        logic [3:0] sReg;
        logic [3:0] dReg;
        e0 = errors;
        for (int s = 2; s <= 3; s++) begin
            for (int as = 0; as < 4; as++) begin
                for (int d = 2; d <= 3; d++) begin
                    for (int ad = 0; ad < 2; ad++) begin
                        sReg = 4'(s);
                        dReg = 4'(d);
                        issueInstr({4'h4, sReg, 1'(ad), 1'b0, 2'(as), dReg});
                    end
                end
            end
        end
        reportTest("doubleConst", e0);
    endtask

    task automatic registerOperands();
        int         e0;
        logic [3:0] rr;
        e0 = errors;
        // double format, source and destination outside R2 and R3
        for (int r = 4; r < 15; r++) begin
            rr = 4'(r);
            issueInstr({4'h5, rr, rr[0], 1'b0, rr[2:1], rr + 4'd1});
        end
        // single format on every ordinary register and mode
        for (int r = 0; r < numRegs; r++) begin
            rr = 4'(r);
            if (rr != regCg1 && rr != regCg2) begin
                issueInstr({6'b000100, 3'b000, 1'b0, rr[1:0], rr});
            end
        end
        // a jump word takes the single operand path
        issueInstr(16'h20a5);
        reportTest("registerOps", e0);
    endtask

    task automatic singleConstants();
        int         e0;
        logic [3:0] rr;
        e0 = errors;
        for (int r = 2; r <= 3; r++) begin
            for (int m = 0; m < 4; m++) begin
                rr = 4'(r);
                issueInstr({6'b000100, 3'b000, 1'b0, 2'(m), rr});
            end
        end
        reportTest("singleConst", e0);
    endtask

    task automatic backToBackStream();
        int                   e0;
        logic [31:0]          rnd;
        logic [dataWidth-1:0] inFlight [$];
        e0 = errors;
        for (int cyc = 0; cyc < 42; cyc++) begin
            nextCycle();
            if (cyc < 40) begin
                rnd = $urandom;
                iw = rnd[15:0];
                iwValid = 1'b1;
                inFlight.push_back(rnd[15:0]);
            end else begin
                iwValid = 1'b0;
            end
            // result of the word issued two cycles back
            compareFlag("opValid", opValid, cyc >= 2);
            if (opValid) begin
                if (inFlight.size() == 0) begin
                    errors++;
                    $display("stream: opValid with no instruction in flight at %0t", $time);
                end else begin
                    checkOperands(inFlight.pop_front());
                end
            end
        end
        if (inFlight.size() != 0) begin
            errors++;
            $display("stream: %0d results never came out", inFlight.size());
        end
        reportTest("stream", e0);
    endtask

    initial begin
        void'($urandom(32'hd5fc));
        clk = 1'b0;
        rstN = 1'b0;
        iw = '0;
        iwValid = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int r = 0; r < numRegs; r++) begin
            shadow[r] = '0;
        end

        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        compareFlag("opValid", opValid, 1'b0);
        compareFlag("pslverr", pslverr, 1'b0);

        loadReadback();
        errorResponse();
        doubleConstants();
        registerOperands();
        singleConstants();
        backToBackStream();

        nextCycle();
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, i_dut.i_props.assertFails);
        if (errors == 0 && i_dut.i_props.assertFails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tests/OperandUnitProps.sv
// concurrent checks on APB completion, reset values and pipeline latency, bound into OperandUnit
module OperandUnitProps (
    input logic clk,
    input logic rstN,
    input logic iwValid,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic opValid
);
    // failed assertion count, read by the testbench at the end of the run
    int assertFails = 0;

    // zero wait state slave, every access phase completes at once
    apbReady: assert property (@(posedge clk) psel && penable |-> pready)
        else begin
            assertFails++;
            $error("pready low during an APB access phase");
        end

    // decode plus fetch, fixed two cycles from iwValid to opValid
    pipeLatency: assert property (@(posedge clk) disable iff (!rstN)
        opValid == $past(iwValid, 2))
        else begin
            assertFails++;
            $error("opValid does not follow iwValid by two cycles");
        end

    // reset is synchronous, so opValid is cleared one edge after rstN is seen low
    resetValid: assert property (@(posedge clk) !rstN |=> !opValid)
        else begin
            assertFails++;
            $error("opValid high while in reset");
        end

    resetErr: assert property (@(posedge clk) !rstN |-> !pslverr)
        else begin
            assertFails++;
            $error("pslverr high while in reset");
        end

endmodule

bind OperandUnit OperandUnitProps i_props (
    .clk     (clk),
    .rstN    (rstN),
    .iwValid (iwValid),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .opValid (opValid)
);

// File: verilog/OperandUnit.sv
// operand fetch top, instruction word in and operands out two cycles later, registers via APB
module OperandUnit (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [msp430Pkg::dataWidth-1:0]    iw,
    input  logic                               iwValid,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [msp430Pkg::apbAddrWidth-1:0] paddr,
    input  logic [msp430Pkg::dataWidth-1:0]    pwdata,
    output logic [msp430Pkg::dataWidth-1:0]    prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               opValid,
    output logic [msp430Pkg::dataWidth-1:0]    srcOperand,
    output logic [msp430Pkg::dataWidth-1:0]    dstOperand,
    output logic                               srcIsConst,
    output logic                               dstIsConst
);
    import msp430Pkg::*;

    // decode stage outputs
    logic                   decValid;
    opFormat                decFormat;
    logic [regIdxWidth-1:0] decSrcReg;
    addrMode                decSrcMode;
    logic [regIdxWidth-1:0] decDstReg;
    addrMode                decDstMode;

    // constant generator and register read results, same cycle as decode outputs
    logic [dataWidth-1:0] cgSrc;
    logic [dataWidth-1:0] cgDst;
    logic                 cgSrcHit;
    logic                 cgDstHit;
    logic [dataWidth-1:0] rdSrc;
    logic [dataWidth-1:0] rdDst;

    InstructionDecoder i_decoder (
        .clk        (clk),
        .rstN       (rstN),
        .iw         (iw),
        .iwValid    (iwValid),
        .decValid   (decValid),
        .decFormat  (decFormat),
        .decSrcReg  (decSrcReg),
        .decSrcMode (decSrcMode),
        .decDstReg  (decDstReg),
        .decDstMode (decDstMode)
    );

    ConstantGenerator i_constGen (
        .decFormat  (decFormat),
        .decSrcReg  (decSrcReg),
        .decSrcMode (decSrcMode),
        .decDstReg  (decDstReg),
        .decDstMode (decDstMode),
        .cgSrc      (cgSrc),
        .cgDst      (cgDst),
        .cgSrcHit   (cgSrcHit),
        .cgDstHit   (cgDstHit)
    );

    // read in parallel with the constant table
    RegisterFile i_regFile (
        .clk       (clk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .decSrcReg (decSrcReg),
        .decDstReg (decDstReg),
        .rdSrc     (rdSrc),
        .rdDst     (rdDst)
    );

    OperandFetch i_fetch (
        .clk        (clk),
        .rstN       (rstN),
        .decValid   (decValid),
        .decFormat  (decFormat),
        .cgSrc      (cgSrc),
        .cgDst      (cgDst),
        .cgSrcHit   (cgSrcHit),
        .cgDstHit   (cgDstHit),
        .rdSrc      (rdSrc),
        .rdDst      (rdDst),
        .opValid    (opValid),
        .srcOperand (srcOperand),
        .dstOperand (dstOperand),
        .srcIsConst (srcIsConst),
        .dstIsConst (dstIsConst)
    );

endmodule

// File: verilog/OperandFetch.sv
// second pipeline stage, chooses constant or register data per operand and registers the result
module OperandFetch (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            decValid,
    input  msp430Pkg::opFormat              decFormat,
    input  logic [msp430Pkg::dataWidth-1:0] cgSrc,
    input  logic [msp430Pkg::dataWidth-1:0] cgDst,
    input  logic                            cgSrcHit,
    input  logic                            cgDstHit,
    input  logic [msp430Pkg::dataWidth-1:0] rdSrc,
    input  logic [msp430Pkg::dataWidth-1:0] rdDst,
    output logic                            opValid,
    output logic [msp430Pkg::dataWidth-1:0] srcOperand,
    output logic [msp430Pkg::dataWidth-1:0] dstOperand,
    output logic                            srcIsConst,
    output logic                            dstIsConst
);
    import msp430Pkg::*;

    // selected values ahead of the output register
    logic [dataWidth-1:0] nextSrc;
    logic [dataWidth-1:0] nextDst;
    logic                 nextSrcConst;
    logic                 nextDstConst;

    always_comb begin
        // dst path always carries an operand
        nextDst      = cgDstHit ? cgDst : rdDst;
        nextDstConst = cgDstHit;

        if (decFormat == fmtDouble) begin
            nextSrc      = cgSrcHit ? cgSrc : rdSrc;
            nextSrcConst = cgSrcHit;
        end else begin
            // no source operand in single format
            // rdSrc points at R0 here and must not leak out
            nextSrc      = '0;
            nextSrcConst = 1'b0;
        end
    end

    // output strobe, one cycle behind decValid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else begin
            opValid <= decValid;
        end
    end

    // operands and their constant flags, held between instructions
    always_ff @(posedge clk) begin
        if (decValid) begin
            srcOperand <= nextSrc;
            dstOperand <= nextDst;
            srcIsConst <= nextSrcConst;
            dstIsConst <= nextDstConst;
        end
    end

endmodule

// File: verilog/RegisterFile.sv
// CPU register array read by the pipeline and loaded or inspected by a debugger over APB
module RegisterFile (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [msp430Pkg::apbAddrWidth-1:0] paddr,
    input  logic [msp430Pkg::dataWidth-1:0]    pwdata,
    output logic [msp430Pkg::dataWidth-1:0]    prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic [msp430Pkg::regIdxWidth-1:0]  decSrcReg,
    input  logic [msp430Pkg::regIdxWidth-1:0]  decDstReg,
    output logic [msp430Pkg::dataWidth-1:0]    rdSrc,
    output logic [msp430Pkg::dataWidth-1:0]    rdDst
);
    import msp430Pkg::*;

    // R0 to R15
    logic [dataWidth-1:0] regs [numRegs];

    // APB decode
    logic                   access;
    logic                   addrOk;
    logic [regIdxWidth-1:0] wordIdx;

    // access phase, psel and penable both high
    assign access = psel && penable;

    // must be word aligned and inside R0..R15
    assign addrOk = (paddr <= apbAddrWidth'(regAddrMax)) && !paddr[0];

    // drop the byte offset bit to get the register number
    assign wordIdx = paddr[regIdxWidth:1];

    // zero wait states, every access completes in one cycle
    assign pready = 1'b1;

    // error only flagged while the bad access is in its access phase
    assign pslverr = access && !addrOk;

    // read data valid during a good read access, zero otherwise
    always_comb begin
        if (access && !pwrite && addrOk) begin
            prdata = regs[wordIdx];
        end else begin
            prdata = '0;
        end
    end

    // debug writes land at the end of the access phase
    // a rejected address leaves the array untouched
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (access && pwrite && addrOk) begin
            regs[wordIdx] <= pwdata;
        end
    end

    // pipeline read ports, asynchronous
    // a same-cycle APB write is only visible after the edge
    assign rdSrc = regs[decSrcReg];
    assign rdDst = regs[decDstReg];

endmodule

// File: verilog/ConstantGenerator.sv
// combinational CG1/CG2 decode that turns register and mode pairs into immediate operands
module ConstantGenerator (
    input  msp430Pkg::opFormat                decFormat,
    input  logic [msp430Pkg::regIdxWidth-1:0] decSrcReg,
    input  msp430Pkg::addrMode                decSrcMode,
    input  logic [msp430Pkg::regIdxWidth-1:0] decDstReg,
    input  msp430Pkg::addrMode                decDstMode,
    output logic [msp430Pkg::dataWidth-1:0]   cgSrc,
    output logic [msp430Pkg::dataWidth-1:0]   cgDst,
    output logic                              cgSrcHit,
    output logic                              cgDstHit
);
    import msp430Pkg::*;

    // full As table shared by the double format source and the single format operand
    // result is {hit, value}
    function automatic logic [dataWidth:0] fourModeConst(
        input logic [regIdxWidth-1:0] regIdx,
        input addrMode                mode
    );
        logic [dataWidth:0] result;
        result = '0;
        if (regIdx == regCg1) begin
            // register mode on CG1 is a plain SR access, no constant
            case (mode)
                modeIndexed:         result = {1'b1, 16'h0000};
                modeIndirect:        result = {1'b1, 16'h0004};
                modeIndirectAutoInc: result = {1'b1, 16'h0008};
                default:             result = '0;
            endcase
        end else if (regIdx == regCg2) begin
            // R3 generates in every mode
            case (mode)
                modeRegister:        result = {1'b1, 16'h0000};
                modeIndexed:         result = {1'b1, 16'h0001};
                modeIndirect:        result = {1'b1, 16'h0002};
                modeIndirectAutoInc: result = {1'b1, 16'hffff};
                default:             result = '0;
            endcase
        end
        return result;
    endfunction

    always_comb begin
        // nothing generated unless a table entry matches
        cgSrc    = '0;
        cgSrcHit = 1'b0;
        cgDst    = '0;
        cgDstHit = 1'b0;

        if (decFormat == fmtDouble) begin
            {cgSrcHit, cgSrc} = fourModeConst(decSrcReg, decSrcMode);
            // a generated destination is odd for the assembler but still defined
            // Ad only reaches us as register or indexed
            if (decDstReg == regCg1 && decDstMode == modeIndexed) begin
                cgDst    = 16'h0000;
                cgDstHit = 1'b1;
            end else if (decDstReg == regCg2 && decDstMode == modeRegister) begin
                cgDst    = 16'h0000;
                cgDstHit = 1'b1;
            end else if (decDstReg == regCg2 && decDstMode == modeIndexed) begin
                cgDst    = 16'h0001;
                cgDstHit = 1'b1;
            end
        end else begin
            // single operand and jump words, src stays idle
            {cgDstHit, cgDst} = fourModeConst(decDstReg, decDstMode);
        end
    end

endmodule

// File: verilog/InstructionDecoder.sv
// first pipeline stage, splits an incoming instruction word into format, register and mode fields
module InstructionDecoder (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [msp430Pkg::dataWidth-1:0]   iw,
    input  logic                              iwValid,
    output logic                              decValid,
    output msp430Pkg::opFormat                decFormat,
    output logic [msp430Pkg::regIdxWidth-1:0] decSrcReg,
    output msp430Pkg::addrMode                decSrcMode,
    output logic [msp430Pkg::regIdxWidth-1:0] decDstReg,
    output msp430Pkg::addrMode                decDstMode
);
    import msp430Pkg::*;

    // field values for the word currently on iw
    opFormat                nextFormat;
    logic [regIdxWidth-1:0] nextSrcReg;
    addrMode                nextSrcMode;
    logic [regIdxWidth-1:0] nextDstReg;
    addrMode                nextDstMode;

    always_comb begin
        if (iw[iwFmtMsb:iwFmtLsb] == 2'b00) begin
            nextFormat = fmtSingle;
        end else begin
            nextFormat = fmtDouble;
        end

        if (nextFormat == fmtDouble) begin
            nextSrcReg  = iw[iwSrcRegMsb:iwSrcRegLsb];
            nextSrcMode = addrMode'(iw[iwModeMsb:iwModeLsb]);
            nextDstReg  = iw[iwRegMsb:iwRegLsb];
            // Ad is a single bit, so only register and indexed can appear here
            nextDstMode = addrMode'({1'b0, iw[iwDstModeBit]});
        end else begin
            // single operand words carry their operand on the dst path
            // As still selects the mode, see the single operand format
            nextSrcReg  = '0;
            nextSrcMode = modeRegister;
            nextDstReg  = iw[iwRegMsb:iwRegLsb];
            nextDstMode = addrMode'(iw[iwModeMsb:iwModeLsb]);
        end
    end

    // valid strobe, one cycle behind iwValid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= iwValid;
        end
    end

    // field register, held while no instruction arrives
    always_ff @(posedge clk) begin
        if (iwValid) begin
            decFormat  <= nextFormat;
            decSrcReg  <= nextSrcReg;
            decSrcMode <= nextSrcMode;
            decDstReg  <= nextDstReg;
            decDstMode <= nextDstMode;
        end
    end

endmodule

// File: verilog/msp430Pkg.sv
// shared register indices, instruction field positions and types for the operand fetch stage
package msp430Pkg;

    // datapath word and register file geometry
    localparam int dataWidth = 16;
    localparam int numRegs = 16;
    localparam int regIdxWidth = 4;

    // R2 doubles as the status register and CG1, R3 is CG2
    localparam logic [regIdxWidth-1:0] regCg1 = 4'd2;
    localparam logic [regIdxWidth-1:0] regCg2 = 4'd3;

    // debug port uses byte addresses, register n lives at 2n
    localparam int apbAddrWidth = 8;
    // highest legal word-aligned byte address
    localparam int regAddrMax = 2 * (numRegs - 1);

    // instruction word field positions
    // bits 15:14 both zero mark single operand and jump words
    localparam int iwFmtMsb = 15;
    localparam int iwFmtLsb = 14;
    // source register of a double operand word
    localparam int iwSrcRegMsb = 11;
    localparam int iwSrcRegLsb = 8;
    // Ad, the one-bit destination mode of a double operand word
    localparam int iwDstModeBit = 7;
    // As, source mode in double format and the only mode in single format
    localparam int iwModeMsb = 5;
    localparam int iwModeLsb = 4;
    // destination register in double format, the lone register in single format
    localparam int iwRegMsb = 3;
    localparam int iwRegLsb = 0;

    // the four MSP430 addressing modes, encoded as the As field
    typedef enum logic [1:0] {
        modeRegister        = 2'b00,
        modeIndexed         = 2'b01,
        modeIndirect        = 2'b10,
        modeIndirectAutoInc = 2'b11
    } addrMode;

    // instruction layout as seen by operand fetch
    // jumps fall into fmtSingle since only bits 15:14 are inspected
    typedef enum logic {
        fmtSingle = 1'b0,
        fmtDouble = 1'b1
    } opFormat;

endpackage
